// ==== Bender.yml ====
package:
  name: decode_front

export_include_dirs:
  - common

sources:
  - common/fetch_pkg.sv
  - common/decode_pkg.sv
  - src/entry_fifo.sv
  - id_stage/compressed_decoder.sv
  - id_stage/instr_decoder.sv
  - id_stage/id_stage.sv
  - src/decode_top.sv
  - target: simulation
    files:
      - testbench/tb_decode_top.sv

// ==== common/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Depth of the queue between fetch and decode
`define DEC_FETCH_DEPTH 4

// Depth of the queue between decode and issue
`define DEC_ISSUE_DEPTH 2

// Cause code for an illegal instruction
`define DEC_CAUSE_ILLEGAL 4'd2

`endif

// ==== common/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

  // --------------------
  // Major opcodes
  // --------------------
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  // Exception attached to a decoded entry
  typedef struct packed {
    logic        valid;
    logic [3:0]  cause;
    logic [31:0] tval;
  } exception_t;

  // Functional unit that executes the entry
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_LOAD,
    FU_STORE,
    FU_BRANCH,
    FU_JUMP
  } fu_t;

  // Operation within the functional unit
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_LUI, OP_AUIPC,
    OP_LW, OP_SW,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
    OP_JAL, OP_JALR
  } op_t;

  // --------------------
  // Scoreboard entry
  // --------------------
  typedef struct packed {
    logic [31:0] pc;
    fu_t         fu;
    op_t         op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    // Second operand comes from imm instead of rs2
    logic        use_imm;
    logic [31:0] imm;
    logic        is_compressed;
    exception_t  ex;
  } sb_entry_t;

endpackage

`default_nettype wire

// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // --------------------
  // Fetched instruction
  // --------------------

  // Byte address of an instruction
  typedef logic [31:0] addr_t;

  // Raw instruction word
  // Low 16 bits hold a compressed form when bits [1:0] are not 11
  typedef logic [31:0] instr_word_t;

  // One item handed from fetch to decode
  typedef struct packed {
    addr_t       addr;
    instr_word_t instr;
  } fetch_entry_t;

endpackage

`default_nettype wire

// ==== id_stage/compressed_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module compressed_decoder (
  input  wire logic [31:0] instr_i,
  output logic      [31:0] instr_o,
  output logic             is_compressed_o,
  output logic             illegal_o
);

  always_comb begin
    // Full words and unsupported forms pass through untouched
    instr_o         = instr_i;
    is_compressed_o = 1'b0;
    illegal_o       = 1'b0;

    if (instr_i[1:0] != 2'b11) begin
      is_compressed_o = 1'b1;
      case (instr_i[1:0])
        // --------------------
        // Quadrant 0
        // --------------------
        2'b00: begin
          case (instr_i[15:13])
            // C.LW to lw rd', off(rs1')
            3'b010: begin
              instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                         2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], 7'b0000011};
            end
            // C.SW to sw rs2', off(rs1')
            3'b110: begin
              instr_o = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                         2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                         2'b00, 7'b0100011};
            end
            default: illegal_o = 1'b1;
          endcase
        end

        // --------------------
        // Quadrant 1
        // --------------------
        2'b01: begin
          case (instr_i[15:13])
            // C.ADDI to addi rd, rd, imm
            3'b000: begin
              instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                         3'b000, instr_i[11:7], 7'b0010011};
            end
            // C.LI to addi rd, x0, imm
            3'b010: begin
              instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b0,
                         3'b000, instr_i[11:7], 7'b0010011};
            end
            // C.J to jal x0, off
            // Offset bits are scattered, reorder into the J layout
            3'b101: begin
              instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                         instr_i[2], instr_i[11], instr_i[5:3], instr_i[12],
                         {8{instr_i[12]}}, 5'b0, 7'b1101111};
            end
            // C.BEQZ to beq rs1', x0, off
            3'b110: begin
              instr_o = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'b0, 2'b01,
                         instr_i[9:7], 3'b000, instr_i[11:10], instr_i[4:3],
                         instr_i[12], 7'b1100011};
            end
            default: illegal_o = 1'b1;
          endcase
        end

        // --------------------
        // Quadrant 2
        // --------------------
        default: begin
          // Only C.MV and C.ADD, both need a nonzero rs2
          if ((instr_i[15:13] == 3'b100) && (instr_i[6:2] != 5'b0)) begin
            if (instr_i[12]) begin
              // C.ADD to add rd, rd, rs2
              instr_o = {7'b0, instr_i[6:2], instr_i[11:7], 3'b000,
                         instr_i[11:7], 7'b0110011};
            end else begin
              // C.MV to add rd, x0, rs2
              instr_o = {7'b0, instr_i[6:2], 5'b0, 3'b000, instr_i[11:7], 7'b0110011};
            end
          end else begin
            illegal_o = 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== id_stage/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage import fetch_pkg::*; import decode_pkg::*; (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         flush_i,
  // Fetch side
  input  wire logic         entry_valid_i,
  input  wire fetch_entry_t entry_data_i,
  output logic              entry_ready_o,
  // Issue side
  output logic              issue_valid_o,
  output sb_entry_t         issue_entry_o,
  input  wire logic         issue_ack_i
);

  logic [31:0] expanded_instr;
  logic        is_compressed;
  logic        is_illegal_c;
  sb_entry_t   decoded_entry;
  logic        load_en;
  logic        valid_q;
  sb_entry_t   entry_q;

  // --------------------
  // Expand compressed
  // --------------------
  compressed_decoder u_compressed_decoder (
    .instr_i         (entry_data_i.instr),
    .instr_o         (expanded_instr),
    .is_compressed_o (is_compressed),
    .illegal_o       (is_illegal_c)
  );

  // --------------------
  // Decode
  // --------------------
  instr_decoder u_instr_decoder (
    .pc_i            (entry_data_i.addr),
    .instr_i         (expanded_instr),
    .is_compressed_i (is_compressed),
    .illegal_i       (is_illegal_c),
    .entry_o         (decoded_entry)
  );

  // Register has room when empty or draining this cycle
  assign load_en       = entry_valid_i & (~valid_q | issue_ack_i) & ~flush_i;
  assign entry_ready_o = load_en;

  assign issue_valid_o = valid_q;
  assign issue_entry_o = entry_q;

  // --------------------
  // Decode to issue register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load_en) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  // Entry holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (load_en) begin
      entry_q <= decoded_entry;
    end
  end

endmodule

`default_nettype wire

// ==== id_stage/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "decode_macros.svh"

module instr_decoder import decode_pkg::*; (
  input  wire logic [31:0] pc_i,
  input  wire logic [31:0] instr_i,
  input  wire logic        is_compressed_i,
  input  wire logic        illegal_i,
  output sb_entry_t        entry_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        illegal_enc;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // --------------------
  // Immediates
  // --------------------
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.is_compressed = is_compressed_i;
    entry_o.fu            = FU_NONE;
    entry_o.op            = OP_ADD;
    illegal_enc           = 1'b0;

    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        entry_o.fu      = FU_ALU;
        entry_o.op      = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
        entry_o.rd      = instr_i[11:7];
        entry_o.use_imm = 1'b1;
        entry_o.imm     = imm_u;
      end

      OPC_OP_IMM: begin
        entry_o.fu      = FU_ALU;
        entry_o.rs1     = instr_i[19:15];
        entry_o.rd      = instr_i[11:7];
        entry_o.use_imm = 1'b1;
        entry_o.imm     = imm_i;
        case (funct3)
          3'b000: entry_o.op = OP_ADD;
          3'b010: entry_o.op = OP_SLT;
          3'b011: entry_o.op = OP_SLTU;
          3'b100: entry_o.op = OP_XOR;
          3'b110: entry_o.op = OP_OR;
          3'b111: entry_o.op = OP_AND;
          // Shifts constrain the upper immediate bits
          3'b001: begin
            entry_o.op  = OP_SLL;
            illegal_enc = (funct7 != 7'b0000000);
          end
          default: begin
            if (funct7 == 7'b0000000) begin
              entry_o.op = OP_SRL;
            end else if (funct7 == 7'b0100000) begin
              entry_o.op = OP_SRA;
            end else begin
              illegal_enc = 1'b1;
            end
          end
        endcase
      end

      OPC_OP: begin
        entry_o.fu  = FU_ALU;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.rd  = instr_i[11:7];
        case ({funct7, funct3})
          10'b0000000_000: entry_o.op = OP_ADD;
          10'b0100000_000: entry_o.op = OP_SUB;
          10'b0000000_001: entry_o.op = OP_SLL;
          10'b0000000_010: entry_o.op = OP_SLT;
          10'b0000000_011: entry_o.op = OP_SLTU;
          10'b0000000_100: entry_o.op = OP_XOR;
          10'b0000000_101: entry_o.op = OP_SRL;
          10'b0100000_101: entry_o.op = OP_SRA;
          10'b0000000_110: entry_o.op = OP_OR;
          10'b0000000_111: entry_o.op = OP_AND;
          default:         illegal_enc = 1'b1;
        endcase
      end

      // Word accesses only
      OPC_LOAD: begin
        entry_o.fu      = FU_LOAD;
        entry_o.op      = OP_LW;
        entry_o.rs1     = instr_i[19:15];
        entry_o.rd      = instr_i[11:7];
        entry_o.use_imm = 1'b1;
        entry_o.imm     = imm_i;
        illegal_enc     = (funct3 != 3'b010);
      end

      // Store data is rs2, so the immediate is not the second operand
      OPC_STORE: begin
        entry_o.fu  = FU_STORE;
        entry_o.op  = OP_SW;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.imm = imm_s;
        illegal_enc = (funct3 != 3'b010);
      end

      OPC_BRANCH: begin
        entry_o.fu  = FU_BRANCH;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.imm = imm_b;
        case (funct3)
          3'b000:  entry_o.op = OP_BEQ;
          3'b001:  entry_o.op = OP_BNE;
          3'b100:  entry_o.op = OP_BLT;
          3'b101:  entry_o.op = OP_BGE;
          default: illegal_enc = 1'b1;
        endcase
      end

      OPC_JAL: begin
        entry_o.fu      = FU_JUMP;
        entry_o.op      = OP_JAL;
        entry_o.rd      = instr_i[11:7];
        entry_o.use_imm = 1'b1;
        entry_o.imm     = imm_j;
      end

      OPC_JALR: begin
        entry_o.fu      = FU_JUMP;
        entry_o.op      = OP_JALR;
        entry_o.rs1     = instr_i[19:15];
        entry_o.rd      = instr_i[11:7];
        entry_o.use_imm = 1'b1;
        entry_o.imm     = imm_i;
        illegal_enc     = (funct3 != 3'b000);
      end

      default: illegal_enc = 1'b1;
    endcase

    // Illegal entries keep only pc and the compressed flag
    // Unsupported compressed words arrive here unexpanded
    if (illegal_enc || illegal_i) begin
      entry_o          = '0;
      entry_o.pc       = pc_i;
      entry_o.fu       = FU_NONE;
      entry_o.op       = OP_ADD;
      entry_o.is_compressed = is_compressed_i;
      entry_o.ex.valid = 1'b1;
      entry_o.ex.cause = `DEC_CAUSE_ILLEGAL;
      entry_o.ex.tval  = instr_i;
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/fetch_pkg.sv
common/decode_pkg.sv
src/entry_fifo.sv
id_stage/compressed_decoder.sv
id_stage/instr_decoder.sv
id_stage/id_stage.sv
src/decode_top.sv
testbench/tb_decode_top.sv

// ==== src/decode_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "decode_macros.svh"

module decode_top import fetch_pkg::*; import decode_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        flush_i,
  // Fetch handshake
  input  wire logic        fetch_valid_i,
  input  wire logic [31:0] fetch_addr_i,
  input  wire logic [31:0] fetch_instr_i,
  output logic             fetch_ready_o,
  // Issue handshake
  output logic             issue_valid_o,
  output sb_entry_t        issue_entry_o,
  input  wire logic        issue_ack_i
);

  fetch_entry_t fetch_in;
  logic         fetch_full;
  logic         entry_valid;
  fetch_entry_t entry_data;
  logic         entry_ready;
  logic         issue_valid;
  sb_entry_t    issue_entry;
  logic         issue_ack;
  logic         issue_full;

  assign fetch_in.addr  = fetch_addr_i;
  assign fetch_in.instr = fetch_instr_i;
  assign fetch_ready_o  = ~fetch_full;

  // Issue queue takes the entry whenever it has room
  assign issue_ack = issue_valid & ~issue_full;

  // --------------------
  // Fetch queue
  // --------------------
  entry_fifo #(
    .payload_t (fetch_entry_t),
    .DEPTH     (`DEC_FETCH_DEPTH)
  ) u_fetch_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .push_i  (fetch_valid_i),
    .data_i  (fetch_in),
    .full_o  (fetch_full),
    .pop_i   (entry_ready),
    .data_o  (entry_data),
    .valid_o (entry_valid)
  );

  // Decode and pipeline register
  id_stage u_id_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .entry_valid_i (entry_valid),
    .entry_data_i  (entry_data),
    .entry_ready_o (entry_ready),
    .issue_valid_o (issue_valid),
    .issue_entry_o (issue_entry),
    .issue_ack_i   (issue_ack)
  );

  // --------------------
  // Issue queue
  // --------------------
  entry_fifo #(
    .payload_t (sb_entry_t),
    .DEPTH     (`DEC_ISSUE_DEPTH)
  ) u_issue_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .push_i  (issue_valid),
    .data_i  (issue_entry),
    .full_o  (issue_full),
    .pop_i   (issue_ack_i),
    .data_o  (issue_entry_o),
    .valid_o (issue_valid_o)
  );

endmodule

`default_nettype wire

// ==== src/entry_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module entry_fifo #(
  parameter type payload_t = logic,
  parameter int unsigned DEPTH = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     flush_i,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  output logic          full_o,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          valid_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t           mem_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push_en;
  logic               pop_en;

  // Head of storage is the output, so data is always registered
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Flush drops anything offered in the same cycle
  assign push_en = push_i & ~full_o & ~flush_i;
  assign pop_en  = pop_i & valid_o & ~flush_i;

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        // Wrap at the last slot
        if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop_en) begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Simultaneous push and pop keeps the count
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_decode_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "decode_macros.svh"

module tb_decode_top import decode_pkg::*; ();

  localparam int unsigned CLK_PERIOD    = 4;
  localparam int unsigned PIPE_CAPACITY = `DEC_FETCH_DEPTH + 1 + `DEC_ISSUE_DEPTH;
  localparam int unsigned MARGIN_NS     = 2000;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_addr_i;
  logic [31:0] fetch_instr_i;
  logic        fetch_ready_o;
  logic        issue_valid_o;
  sb_entry_t   issue_entry_o;
  logic        issue_ack_i;

  // Program table and its expected entries
  logic [31:0] row_addr[$];
  logic [31:0] row_word[$];
  sb_entry_t   exp_tab[$];
  logic [31:0] next_addr   = 32'h0000_1000;
  logic        rows_loaded = 1'b0;

  // Entries accepted by fetch and not yet issued
  sb_entry_t   exp_q[$];
  sb_entry_t   exp_head    = '0;
  int unsigned exp_count   = 0;
  int unsigned offer_row   = 0;
  int unsigned fetch_cnt   = 0;
  int unsigned issued_cnt  = 0;
  int unsigned err_cnt     = 0;
  integer      seed;

  decode_top u_decode_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_valid_o (issue_valid_o),
    .issue_entry_o (issue_entry_o),
    .issue_ack_i   (issue_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  // --------------------
  // Program table
  // --------------------
  task automatic push_row(input logic [31:0] word, input sb_entry_t e);
    row_addr.push_back(next_addr);
    row_word.push_back(word);
    exp_tab.push_back(e);
    // Compressed words take two bytes
    next_addr = next_addr + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
  endtask

  task automatic add_row(input logic [31:0] word, input fu_t fu, input op_t op,
                         input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                         input logic use_imm, input logic [31:0] imm);
    sb_entry_t e;
    e               = '0;
    e.pc            = next_addr;
    e.fu            = fu;
    e.op            = op;
    e.rs1           = rs1;
    e.rs2           = rs2;
    e.rd            = rd;
    e.use_imm       = use_imm;
    e.imm           = imm;
    e.is_compressed = (word[1:0] != 2'b11);
    push_row(word, e);
  endtask

  // Illegal entry keeps pc and compressed flag, tval is the fetched word
  task automatic add_illegal(input logic [31:0] word);
    sb_entry_t e;
    e               = '0;
    e.pc            = next_addr;
    e.fu            = FU_NONE;
    e.op            = OP_ADD;
    e.is_compressed = (word[1:0] != 2'b11);
    e.ex.valid      = 1'b1;
    e.ex.cause      = `DEC_CAUSE_ILLEGAL;
    e.ex.tval       = word;
    push_row(word, e);
  endtask

  task automatic load_program();
    // addi x1, x2, -5
    add_row(32'hFFB10093, FU_ALU, OP_ADD, 5'd2, 5'd0, 5'd1, 1'b1, 32'hFFFFFFFB);
    // c.addi x8, -1
    add_row(32'h0000147D, FU_ALU, OP_ADD, 5'd8, 5'd0, 5'd8, 1'b1, 32'hFFFFFFFF);
    // c.li x10, 5
    add_row(32'h00004515, FU_ALU, OP_ADD, 5'd0, 5'd0, 5'd10, 1'b1, 32'h00000005);
    // sub x3, x4, x5
    add_row(32'h405201B3, FU_ALU, OP_SUB, 5'd4, 5'd5, 5'd3, 1'b0, 32'h0);
    // srai x6, x7, 3 keeps funct7 in the I immediate
    add_row(32'h4033D313, FU_ALU, OP_SRA, 5'd7, 5'd0, 5'd6, 1'b1, 32'h00000403);
    // c.mv x11, x12
    add_row(32'h000085B2, FU_ALU, OP_ADD, 5'd0, 5'd12, 5'd11, 1'b0, 32'h0);
    // c.add x13, x14
    add_row(32'h000096BA, FU_ALU, OP_ADD, 5'd13, 5'd14, 5'd13, 1'b0, 32'h0);
    // lui x8, 0x12345
    add_row(32'h12345437, FU_ALU, OP_LUI, 5'd0, 5'd0, 5'd8, 1'b1, 32'h12345000);
    // auipc x9, 0x1
    add_row(32'h00001497, FU_ALU, OP_AUIPC, 5'd0, 5'd0, 5'd9, 1'b1, 32'h00001000);
    // lb is outside the subset
    add_illegal(32'h00010083);
    // lw x10, 8(x11)
    add_row(32'h0085A503, FU_LOAD, OP_LW, 5'd11, 5'd0, 5'd10, 1'b1, 32'h00000008);
    // c.lw x9, 4(x10)
    add_row(32'h00004144, FU_LOAD, OP_LW, 5'd10, 5'd0, 5'd9, 1'b1, 32'h00000004);
    // sw x12, -4(x13)
    add_row(32'hFEC6AE23, FU_STORE, OP_SW, 5'd13, 5'd12, 5'd0, 1'b0, 32'hFFFFFFFC);
    // c.sw x8, 8(x15)
    add_row(32'h0000C780, FU_STORE, OP_SW, 5'd15, 5'd8, 5'd0, 1'b0, 32'h00000008);
    // Quadrant 0 all zero word
    add_illegal(32'h00000000);
    // bne x14, x15, +16
    add_row(32'h00F71863, FU_BRANCH, OP_BNE, 5'd14, 5'd15, 5'd0, 1'b0, 32'h00000010);
    // blt x1, x2, -8
    add_row(32'hFE20CCE3, FU_BRANCH, OP_BLT, 5'd1, 5'd2, 5'd0, 1'b0, 32'hFFFFFFF8);
    // c.beqz x9, +8
    add_row(32'h0000C481, FU_BRANCH, OP_BEQ, 5'd9, 5'd0, 5'd0, 1'b0, 32'h00000008);
    // mul needs the M extension
    add_illegal(32'h02208033);
    // bge x3, x4, +4
    add_row(32'h0041D263, FU_BRANCH, OP_BGE, 5'd3, 5'd4, 5'd0, 1'b0, 32'h00000004);
    // c.j +6 and c.j -2
    add_row(32'h0000A019, FU_JUMP, OP_JAL, 5'd0, 5'd0, 5'd0, 1'b1, 32'h00000006);
    add_row(32'h0000BFFD, FU_JUMP, OP_JAL, 5'd0, 5'd0, 5'd0, 1'b1, 32'hFFFFFFFE);
    // c.jr ra is the zero rs2 form of c.mv
    add_illegal(32'h00008082);
    // jal x1, +2048
    add_row(32'h001000EF, FU_JUMP, OP_JAL, 5'd0, 5'd0, 5'd1, 1'b1, 32'h00000800);
    // jalr x0, 0(x1)
    add_row(32'h00008067, FU_JUMP, OP_JALR, 5'd1, 5'd0, 5'd0, 1'b1, 32'h0);
    // c.lwsp
    add_illegal(32'h00004082);
    // ecall
    add_illegal(32'h00000073);
    // and x5, x6, x7
    add_row(32'h007372B3, FU_ALU, OP_AND, 5'd6, 5'd7, 5'd5, 1'b0, 32'h0);
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Tracks handshakes on both ports and the fetch row on offer
  always @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      exp_q.delete();
    end else begin
      if (issue_valid_o && issue_ack_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        issued_cnt++;
      end
      if (fetch_valid_i && fetch_ready_o) begin
        exp_q.push_back(exp_tab[offer_row]);
        fetch_cnt++;
        offer_row = (offer_row + 1) % exp_tab.size();
      end
    end
    exp_count = exp_q.size();
    exp_head  = (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  // --------------------
  // Assertions
  // --------------------
  check_reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!issue_valid_o && fetch_ready_o))
    else report_fail("issue valid high or fetch ready low right after reset");

  check_no_extra: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && issue_ack_i) |-> (exp_count != 0))
    else report_fail("entry issued with nothing outstanding");

  check_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && issue_ack_i && exp_count != 0) |-> (issue_entry_o == exp_head))
    else report_fail("issued entry differs from the expected decode");

  check_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && !issue_ack_i && !flush_i) |=>
    (issue_valid_o && $stable(issue_entry_o)))
    else report_fail("issue entry changed while waiting for ack");

  // All stages full means the fetch queue is full too
  check_full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exp_count == PIPE_CAPACITY) |-> !fetch_ready_o)
    else report_fail("fetch ready high with every stage full");

  check_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (!issue_valid_o && fetch_ready_o))
    else report_fail("pipeline not empty one cycle after flush");

  // Queue, decode register, issue queue
  check_latency: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    (fetch_valid_i && fetch_ready_o && exp_count == 0) |-> ##3 issue_valid_o)
    else report_fail("empty pipeline latency is not 3 cycles");

  // --------------------
  // Stimulus
  // --------------------
  function automatic logic chance(input int unsigned pct);
    int unsigned r;
    r = $unsigned($random(seed)) % 100;
    return (r < pct);
  endfunction

  task automatic drive_inputs(input int unsigned target, input int unsigned valid_pct,
                              input int unsigned ack_pct);
    fetch_valid_i = (fetch_cnt < target) && chance(valid_pct);
    fetch_addr_i  = row_addr[offer_row];
    fetch_instr_i = row_word[offer_row];
    issue_ack_i   = chance(ack_pct);
  endtask

  // Runs until n more fetch handshakes have happened
  task automatic run_phase(input int unsigned n, input int unsigned valid_pct,
                           input int unsigned ack_pct);
    int unsigned target;
    target = fetch_cnt + n;
    drive_inputs(target, valid_pct, ack_pct);
    while (fetch_cnt < target) begin
      @(posedge clk_i);
      #1;
      drive_inputs(target, valid_pct, ack_pct);
    end
  endtask

  task automatic hold_inputs(input int unsigned n, input logic valid, input logic ack);
    repeat (n) begin
      fetch_valid_i = valid;
      fetch_addr_i  = row_addr[offer_row];
      fetch_instr_i = row_word[offer_row];
      issue_ack_i   = ack;
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic drain();
    fetch_valid_i = 1'b0;
    issue_ack_i   = 1'b1;
    while (exp_count != 0 || issue_valid_o) begin
      @(posedge clk_i);
      #1;
    end
    hold_inputs(4, 1'b0, 1'b1);
  endtask

  task automatic apply_flush();
    fetch_valid_i = 1'b0;
    issue_ack_i   = 1'b0;
    flush_i       = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
  endtask

  initial begin : stimulus
    seed          = 32'h62c0;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    fetch_instr_i = '0;
    issue_ack_i   = 1'b0;
    load_program();
    rows_loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Idle edge for the reset state check
    @(posedge clk_i);
    #1;
    // Whole table in order, consumer always ready
    run_phase(exp_tab.size(), 100, 100);
    drain();
    // Random stalls on both ports
    run_phase(2 * exp_tab.size(), 60, 50);
    drain();
    // Consumer stalled until every stage is full
    run_phase(PIPE_CAPACITY, 100, 0);
    hold_inputs(6, 1'b1, 1'b0);
    drain();
    // Flush with entries in flight, then refill
    run_phase(5, 100, 30);
    apply_flush();
    run_phase(exp_tab.size(), 70, 60);
    drain();
    check_drained: assert (exp_count == 0 && !issue_valid_o)
      else report_fail("entries left over after the final drain");
    $display("Fetched: %0d, issued: %0d, errors: %0d", fetch_cnt, issued_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Limit scales with the table length
  initial begin : watchdog
    int unsigned limit_ns;
    wait (rows_loaded === 1'b1);
    limit_ns = exp_tab.size() * 40 * CLK_PERIOD + MARGIN_NS;
    #(limit_ns);
    err_cnt++;
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Fetched: %0d, issued: %0d, errors: %0d", fetch_cnt, issued_cnt, err_cnt);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire
